// File: fpAddSub.sv
`timescale 1ns/100ps
`include "fpAlu_consts.svh"

module fpAddSub import fpAluPkg::*;
(
	input fpWord n1,
	input fpWord n2,
	input fpOp op,
	fpResultIf.unit res
);

	logic e1Ge;
	logic [`FP_EXP_W-1:0] rawDiff;
	logic [`FP_EXP_W-1:0] expDiff;
	logic [`FP_EXP_W-1:0] bigExp;
	logic [`FP_EXP_W-1:0] incExp;
	logic [`FP_EXP_W-1:0] newExp;
	logic [`FP_EXP_W:0] finalExp;
	fpSig sig1;
	fpSig sig2;
	fpSig m1;
	fpSig m2;
	fpSig m2Op;
	fpSig sum;
	fpSig magSig;
	logic effSub;
	logic carry;
	logic finalSign;
	logic [`FP_MANT_W-1:0] normMant;
	fpShift shift;

	assign res.exception = (n1.exp == `FP_EXP_W'(`FP_EXP_MAX)) ||
		(n2.exp == `FP_EXP_W'(`FP_EXP_MAX));

	// A zero exponent marks a denormal whose implied bit is clear
	assign sig1 = {|n1.exp, n1.mant};
	assign sig2 = {|n2.exp, n2.mant};

	////////////////////////////////////////////////////////////
	// Exponent alignment
	////////////////////////////////////////////////////////////

	// Carry out of E1 - E2 is set when E1 is not smaller than E2
	assign {e1Ge, rawDiff} = {1'b0, n1.exp} + {1'b0, ~n2.exp} + {{`FP_EXP_W{1'b0}}, 1'b1};
	assign expDiff = e1Ge ? rawDiff : (~rawDiff + `FP_EXP_W'(1));
	assign bigExp = e1Ge ? n1.exp : n2.exp;

	// Bits shifted out of the smaller operand are simply lost
	assign m1 = e1Ge ? sig1 : (sig1 >> expDiff);
	assign m2 = e1Ge ? (sig2 >> expDiff) : sig2;

	////////////////////////////////////////////////////////////
	// Mantissa add or subtract
	////////////////////////////////////////////////////////////

	// Subtraction happens when exactly one of op and the sign mismatch asks for it
	assign effSub = op[0] ^ n1.sign ^ n2.sign;
	assign m2Op = effSub ? ~m2 : m2;
	assign {carry, sum} = {1'b0, m1} + {1'b0, m2Op} + {{`FP_SIG_W{1'b0}}, effSub};

	// No carry on a subtraction means m2 was the larger one
	assign finalSign = (!n1.sign && effSub && !carry) || (!effSub && n1.sign) ||
		(carry && n1.sign);

	assign magSig = (effSub && !carry) ? (~sum + fpSig'(1)) : sum;

	fpNormalize i_normalize
	(
		.sig(magSig),
		.carry(carry),
		.effSub(effSub),
		.normMant(normMant),
		.shift(shift)
	);

	////////////////////////////////////////////////////////////
	// Exponent adjust and range flags
	////////////////////////////////////////////////////////////

	assign incExp = bigExp + `FP_EXP_W'(1);
	assign newExp = (carry && !effSub) ? incExp : bigExp;

	// Top bit is the borrow of the shift subtraction
	assign finalExp = {1'b0, newExp} - {{(`FP_EXP_W + 1 - `FP_SHIFT_W){1'b0}}, shift};

	assign res.underflow = finalExp[`FP_EXP_W];
	assign res.overflow = (&incExp) && (shift == '0);
	assign res.result = {finalSign, finalExp[`FP_EXP_W-1:0], normMant};

endmodule

// File: fpAlu.f
+incdir+.
fpAluPkg.sv
fpResultIf.sv
fpNormalize.sv
fpAddSub.sv
fpMultiply.sv
fpResultSelect.sv
fpAlu.sv
tbFpAlu.sv

// File: fpAlu.sv
`timescale 1ns/100ps

module fpAlu import fpAluPkg::*;
(
	input logic clk,
	input logic arstN,
	input fpWord n1,
	input fpWord n2,
	input fpOp op,
	output fpWord result,
	output logic overflow,
	output logic underflow,
	output logic exception
);

	fpResultIf addSubRes ();
	fpResultIf mulRes ();

	// Both units see every operation and the selector keeps the one op asks for
	fpAddSub i_addSub
	(
		.n1(n1),
		.n2(n2),
		.op(op),
		.res(addSubRes.unit)
	);

	fpMultiply i_multiply
	(
		.n1(n1),
		.n2(n2),
		.res(mulRes.unit)
	);

	fpResultSelect i_resultSelect
	(
		.clk(clk),
		.arstN(arstN),
		.op(op),
		.addSubRes(addSubRes.sel),
		.mulRes(mulRes.sel),
		.result(result),
		.overflow(overflow),
		.underflow(underflow),
		.exception(exception)
	);

endmodule

// File: fpAluPkg.sv
package fpAluPkg;

`include "fpAlu_consts.svh"

	// One 32-bit word in sign, exponent, mantissa order
	typedef struct packed
	{
		logic sign;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_MANT_W-1:0] mant;
	} fpWord;

	// Bit 1 picks the multiplier, so code 11 multiplies as well
	typedef enum logic [1:0]
	{
		opAdd = 2'b00,
		opSub = 2'b01,
		opMul = 2'b10
	} fpOp;

	// Significand with the implied bit on top
	typedef logic [`FP_SIG_W-1:0] fpSig;

	// Distance the add/sub result moves left during normalization
	typedef logic [`FP_SHIFT_W-1:0] fpShift;

endpackage

// File: fpAlu_consts.svh
`ifndef FP_ALU_CONSTS_SVH
`define FP_ALU_CONSTS_SVH

////////////////////////////////////////////////////////////
// IEEE-754 single precision field layout
////////////////////////////////////////////////////////////

`define FP_EXP_W 8
`define FP_MANT_W 23

// Stored mantissa plus the implied leading bit
`define FP_SIG_W 24
`define FP_WORD_W 32

`define FP_BIAS 127

// Exponent code shared by infinity and NaN
`define FP_EXP_MAX 255

// Wide enough to count a shift across the whole significand
`define FP_SHIFT_W 5

`endif

// File: fpMultiply.sv
`timescale 1ns/100ps
`include "fpAlu_consts.svh"

module fpMultiply import fpAluPkg::*;
(
	input fpWord n1,
	input fpWord n2,
	fpResultIf.unit res
);

	localparam int ProdW = 2 * `FP_SIG_W;

	// Two guard bits hold the sign and the 256 and above range of E1 + E2 - bias
	localparam int ExpCalcW = `FP_EXP_W + 2;

	fpSig sig1;
	fpSig sig2;
	logic [ProdW-1:0] product;
	logic [`FP_MANT_W-1:0] kept;
	logic sticky;
	logic [ExpCalcW-1:0] expCalc;

	assign res.exception = (n1.exp == `FP_EXP_W'(`FP_EXP_MAX)) ||
		(n2.exp == `FP_EXP_W'(`FP_EXP_MAX));

	assign sig1 = {|n1.exp, n1.mant};
	assign sig2 = {|n2.exp, n2.mant};

	assign product = sig1 * sig2;

	////////////////////////////////////////////////////////////
	// Mantissa selection and rounding
	////////////////////////////////////////////////////////////

	// With the top bit set the product is 1x.xxx and the leading one sits one place higher
	assign kept = product[ProdW-1] ? product[ProdW-2 -: `FP_MANT_W] :
		product[ProdW-3 -: `FP_MANT_W];
	assign sticky = product[ProdW-1] ? (|product[`FP_SIG_W-1:0]) :
		(|product[`FP_MANT_W-1:0]);

	////////////////////////////////////////////////////////////
	// Exponent
	////////////////////////////////////////////////////////////

	assign expCalc = ExpCalcW'(n1.exp) + ExpCalcW'(n2.exp) + ExpCalcW'(product[ProdW-1]) -
		ExpCalcW'(`FP_BIAS);

	assign res.underflow = expCalc[ExpCalcW-1];
	assign res.overflow = !expCalc[ExpCalcW-1] && expCalc[ExpCalcW-2];

	// Any discarded one rounds the kept part up once
	assign res.result = {n1.sign ^ n2.sign, expCalc[`FP_EXP_W-1:0],
		kept + {{(`FP_MANT_W-1){1'b0}}, sticky}};

endmodule

// File: fpNormalize.sv
`timescale 1ns/100ps
`include "fpAlu_consts.svh"

module fpNormalize import fpAluPkg::*;
(
	input fpSig sig,
	input logic carry,
	input logic effSub,
	output logic [`FP_MANT_W-1:0] normMant,
	output fpShift shift
);

	fpSig shifted;

	always_comb
	begin
		shift = '0;
		shifted = sig;
		normMant = '0;
		if (carry && !effSub)
		begin
			// The carry is the new leading one, so the sum moves right by one
			normMant = sig[`FP_SIG_W-1:1] + {{(`FP_MANT_W-1){1'b0}}, sig[0]};
		end
		else
		begin
			// Scanning upward lets the highest set bit win
			for (int i = 0; i < `FP_SIG_W; i++)
			begin
				if (sig[i])
				begin
					shift = fpShift'(`FP_SIG_W - 1 - i);
				end
			end
			shifted = sig << shift;
			// The leading one leaves through the top and only the fraction stays
			normMant = shifted[`FP_MANT_W-1:0];
		end
	end

endmodule

// File: fpResultIf.sv
`timescale 1ns/100ps

interface fpResultIf import fpAluPkg::*; ();

	fpWord result;
	logic overflow;
	logic underflow;
	logic exception;

	// Driven by one arithmetic unit
	modport unit
	(
		output result,
		output overflow,
		output underflow,
		output exception
	);

	// Read by the result selector
	modport sel
	(
		input result,
		input overflow,
		input underflow,
		input exception
	);

endinterface

// File: fpResultSelect.sv
`timescale 1ns/100ps
`include "fpAlu_consts.svh"

module fpResultSelect import fpAluPkg::*;
(
	input logic clk,
	input logic arstN,
	input fpOp op,
	fpResultIf.sel addSubRes,
	fpResultIf.sel mulRes,
	output fpWord result,
	output logic overflow,
	output logic underflow,
	output logic exception
);

	fpWord rawResult;
	fpWord forced;
	logic selOverflow;
	logic selUnderflow;
	logic selException;

	always_comb
	begin
		if (op[1])
		begin
			rawResult = mulRes.result;
			selOverflow = mulRes.overflow;
			selUnderflow = mulRes.underflow;
			selException = mulRes.exception;
		end
		else
		begin
			rawResult = addSubRes.result;
			selOverflow = addSubRes.overflow;
			selUnderflow = addSubRes.underflow;
			selException = addSubRes.exception;
		end

		// Overflow wins over underflow, which wins over exception
		if (selOverflow)
			forced = {rawResult.sign, `FP_EXP_W'(`FP_EXP_MAX), {`FP_MANT_W{1'b0}}};
		else if (selUnderflow)
			forced = {rawResult.sign, {(`FP_WORD_W-1){1'b0}}};
		else if (selException)
			forced = {`FP_WORD_W{1'b1}};
		else
			forced = rawResult;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			result <= '0;
			overflow <= 1'b0;
			underflow <= 1'b0;
			exception <= 1'b0;
		end
		else
		begin
			result <= forced;
			overflow <= selOverflow;
			underflow <= selUnderflow;
			exception <= selException;
		end
	end

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tbFpAlu -f fpAlu.f -o simFpAlu

# A $fatal in the testbench gives a nonzero exit status here
./obj_dir/simFpAlu

// File: tbFpAlu.sv
`timescale 1ns/100ps
`include "fpAlu_consts.svh"

module tbFpAlu import fpAluPkg::*; ();

	// Polls happen once per ns, so this covers three clock periods
	localparam int PollLimit = 24;

	logic clk;
	logic arstN;
	fpWord n1;
	fpWord n2;
	fpOp op;
	fpWord result;
	logic overflow;
	logic underflow;
	logic exception;
	int cycleCount = 0;

	// Expected register contents from the operation applied one edge earlier
	fpWord heldWord;
	logic [2:0] heldFlags;

	fpAlu i_dut
	(
		.clk(clk),
		.arstN(arstN),
		.n1(n1),
		.n2(n2),
		.op(op),
		.result(result),
		.overflow(overflow),
		.underflow(underflow),
		.exception(exception)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Exact power of two with a zero stored mantissa
	function automatic fpWord powerOfTwo(input logic sign, input int e);
		fpWord w;
		w.sign = sign;
		w.exp = `FP_EXP_W'(e + `FP_BIAS);
		w.mant = '0;
		return w;
	endfunction

	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Polls between clock edges and returns 1 ns after the next rising edge
	task automatic nextCycle(input string testName);
		int start;
		int polls;
		start = cycleCount;
		polls = 0;
		#0.5;
		while (cycleCount == start)
		begin
			if (polls >= PollLimit)
				stopOnError($sformatf("Timeout waiting for a clock edge in %s", testName));
			else
			begin
				#1;
				polls++;
			end
		end
		#0.5;
	endtask

	task automatic checkWord(input string testName, input fpWord expected, input fpWord actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s expected %h actual %h", testName, expected, actual));
	endtask

	// Flags are ordered overflow, underflow, exception
	task automatic checkFlags(input string testName, input logic [2:0] expected,
		input logic [2:0] actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s flags expected %b actual %b", testName, expected,
				actual));
	endtask

	// The result of an operation shows up exactly one edge after it is applied
	task automatic runOp(input string testName, input fpWord a, input fpWord b, input fpOp code,
		input fpWord expWord, input logic [2:0] expFlags);
		n1 = a;
		n2 = b;
		op = code;
		// Until the next edge the register still holds the previous operation
		#1;
		checkWord({testName, " hold"}, heldWord, result);
		checkFlags({testName, " hold"}, heldFlags, {overflow, underflow, exception});
		nextCycle(testName);
		checkWord(testName, expWord, result);
		checkFlags(testName, expFlags, {overflow, underflow, exception});
		heldWord = expWord;
		heldFlags = expFlags;
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic testReset();
		// An exception operation is pending, so only the reset keeps the register at zero
		n1 = 32'h7F800000;
		n2 = 32'h3F800000;
		op = opAdd;
		for (int i = 0; i < 5; i++)
		begin
			nextCycle("reset");
			checkWord("reset", '0, result);
			checkFlags("reset", 3'b000, {overflow, underflow, exception});
		end
		arstN = 1'b1;
		checkWord("reset release", '0, result);
		checkFlags("reset release", 3'b000, {overflow, underflow, exception});
		heldWord = '0;
		heldFlags = 3'b000;
		runOp("first op after reset", 32'h7F800000, 32'h3F800000, opAdd, 32'hFFFFFFFF,
			3'b001);
	endtask

	task automatic testAddSub();
		runOp("add 1.5 + 2.25", 32'h3FC00000, 32'h40100000, opAdd, 32'h40700000, 3'b000);
		runOp("add 1.5 + -0.5", 32'h3FC00000, 32'hBF000000, opAdd, 32'h3F800000, 3'b000);
		runOp("sub 5.0 - 3.0", 32'h40A00000, 32'h40400000, opSub, 32'h40000000, 3'b000);
		runOp("sub 3.0 - 5.0", 32'h40400000, 32'h40A00000, opSub, 32'hC0000000, 3'b000);
	endtask

	task automatic testMul();
		int a;
		int b;
		logic sa;
		logic sb;
		runOp("mul 3.0 x -2.5", 32'h40400000, 32'hC0200000, opMul, 32'hC0F00000, 3'b000);
		runOp("mul code 11", 32'h40400000, 32'hC0200000, fpOp'(2'b11), 32'hC0F00000, 3'b000);
		// Exponents stay within +-60 so the product never leaves the normal range
		for (int i = 0; i < 20; i++)
		begin
			a = int'($urandom % 121) - 60;
			b = int'($urandom % 121) - 60;
			sa = 1'($urandom);
			sb = 1'($urandom);
			runOp($sformatf("mul 2^%0d x 2^%0d", a, b), powerOfTwo(sa, a), powerOfTwo(sb, b),
				(i % 2 == 0) ? opMul : fpOp'(2'b11), powerOfTwo(sa ^ sb, a + b), 3'b000);
		end
	endtask

	task automatic testRange();
		runOp("overflow +", 32'h71800000, 32'h71800000, opMul, 32'h7F800000, 3'b100);
		runOp("overflow -", 32'hF1800000, 32'h71800000, opMul, 32'hFF800000, 3'b100);
		runOp("underflow", 32'h0D800000, 32'h0D800000, opMul, 32'h00000000, 3'b010);
	endtask

	// Operations follow on consecutive cycles so each result must track its own op
	task automatic testExceptionStream();
		runOp("inf + 1.0", 32'h7F800000, 32'h3F800000, opAdd, 32'hFFFFFFFF, 3'b001);
		runOp("stream mul", 32'h40400000, 32'hC0200000, opMul, 32'hC0F00000, 3'b000);
		runOp("stream sub", 32'h40A00000, 32'h40400000, opSub, 32'h40000000, 3'b000);
		runOp("stream ovf", 32'h71800000, 32'h71800000, opMul, 32'h7F800000, 3'b100);
		runOp("stream add", 32'h3FC00000, 32'h40100000, opAdd, 32'h40700000, 3'b000);
	endtask

	initial
	begin
		int seedValue;
		seedValue = $urandom(32'h1dd4);
		clk = 1'b0;
		arstN = 1'b0;
		n1 = '0;
		n2 = '0;
		op = opAdd;
		testReset();
		testAddSub();
		testMul();
		testRange();
		testExceptionStream();
		$display("Result: PASSED");
		$finish;
	end

endmodule
